//--- mwae_top.f
+incdir+common
common/mwae_pkg.sv
rtl/mwae_config_regs.sv
rtl/mwae_control_fsm.sv
alg1a/alg1a_sequencer.sv
alg1a/alg1a_checker.sv
rtl/mwae_error_log.sv
rtl/mwae_top.sv
verif/mwae_properties.sv
verif/mwae_tb.sv

//--- Bender.yml
package:
  name: mwae

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mwae_pkg.sv
      - rtl/mwae_config_regs.sv
      - rtl/mwae_control_fsm.sv
      - alg1a/alg1a_sequencer.sv
      - alg1a/alg1a_checker.sv
      - rtl/mwae_error_log.sv
      - rtl/mwae_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/mwae_properties.sv
      - verif/mwae_tb.sv

//--- verif/mwae_tb.sv
/*
  Table-driven testbench for the write-and-verify engine.
  The memory model has random ready and read latency, and can flip byte 0
  of one address each time a loop turns from writes to reads.
*/
`timescale 1ns/1ps
`include "mwae_defs.svh"

module mwae_tb;
  import mwae_pkg::*;

  localparam int NUM_ROWS = 7;

  typedef struct packed {
    mwae_cfg_t   cfg;
    logic [31:0] corrupt_addr;
    logic        corrupt_en;
    logic        exp_illegal;
    logic [15:0] disable_after;
  } row_t;

  logic          rtl_clk;
  logic          reset_n;
  mwae_cfg_t     cfg;
  logic          i_clear_error;
  logic          i_mem_ready;
  mwae_mem_rsp_t i_mem_rsp;
  mwae_mem_req_t o_mem_req;
  mwae_status_t  o_status;
  mwae_err_rec_t o_err_rec;

  row_t          table_rows [NUM_ROWS];
  string         row_names [NUM_ROWS];
  string         cur_name;
  row_t          cur;
  mwae_mem_req_t exp_q [$];
  int            loop_q [$];
  int            set_q [$];
  logic [31:0]   rsp_q [$];
  int            due_q [$];
  logic [31:0]   mem [logic [31:0]];
  integer        seed = 32'h1a8621de;
  int            cyc;
  int            limit;
  int            errors;
  int            acc_count;
  int            acc_at_disable;
  logic          last_was_write;
  logic          dis_pending;

  mwae_top i_mwae_top (
    .rtl_clk       (rtl_clk),
    .reset_n       (reset_n),
    .i_cfg         (cfg),
    .i_clear_error (i_clear_error),
    .i_mem_ready   (i_mem_ready),
    .i_mem_rsp     (i_mem_rsp),
    .o_mem_req     (o_mem_req),
    .o_status      (o_status),
    .o_err_rec     (o_err_rec)
  );

  always #10 rtl_clk = ~rtl_clk;

  // Memory content before any write depends on the whole address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] mask);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++)
      if (mask[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  function automatic int request_count(input row_t r);
    return 2 * (r.cfg.num_incrs + 1) * (r.cfg.num_sets + 1) * r.cfg.num_loops;
  endfunction

  function automatic logic [31:0] grid_addr(input row_t r, input int s, input int i);
    return r.cfg.start_addr + s * (r.cfg.set_offset << 6) + i * (r.cfg.addr_incr << 6);
  endfunction

  function automatic logic [31:0] loop_pattern(input row_t r, input int l);
    return r.cfg.pattern + (r.cfg.pattern_incr ? l : 0);
  endfunction

  task automatic check_value(input string what, input logic [127:0] expv,
                             input logic [127:0] act);
    if (expv !== act)
    begin
      $display("Error %s: %s expected %h actual %h", cur_name, what, expv, act);
      errors++;
    end
  endtask

  task automatic set_row(input int idx, input string name, input logic [31:0] start,
                         input logic [25:0] incr, input logic [25:0] set_off,
                         input logic [31:0] pat, input logic [3:0] mask,
                         input logic pincr, input logic [7:0] incrs,
                         input logic [7:0] sets, input logic [7:0] loops,
                         input logic [31:0] corrupt, input logic illegal,
                         input logic [15:0] dis_after);
    row_t r;
    r = '0;
    r.cfg = '{algorithm: 3'd`MWAE_ALG_1A, start_addr: start, addr_incr: incr,
              set_offset: set_off, pattern: pat, byte_mask: mask, pattern_incr: pincr,
              num_incrs: incrs, num_sets: sets, num_loops: loops, force_disable: 1'b0};
    r.corrupt_addr  = corrupt;
    r.corrupt_en    = corrupt != '0;
    r.exp_illegal   = illegal;
    r.disable_after = dis_after;
    table_rows[idx] = r;
    row_names[idx]  = name;
  endtask

  task automatic build_expected(input row_t r);
    mwae_mem_req_t q;
    exp_q.delete();
    loop_q.delete();
    set_q.delete();
    if (r.exp_illegal)
      return;
    for (int l = 0; l < r.cfg.num_loops; l++)
      for (int ph = 0; ph < 2; ph++)
        for (int s = 0; s <= r.cfg.num_sets; s++)
          for (int i = 0; i <= r.cfg.num_incrs; i++)
          begin
            q = '{valid: 1'b1, write: ph == 0, addr: grid_addr(r, s, i),
                  data: loop_pattern(r, l), byte_mask: r.cfg.byte_mask};
            exp_q.push_back(q);
            loop_q.push_back(l);
            set_q.push_back(s);
          end
  endtask

  // The handshake monitor and the memory model sample on the rising edge
  always @(posedge rtl_clk)
  begin
    cyc = cyc + 1;
    if (cyc > limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("TEST FAIL");
      $finish;
    end
    if (reset_n && o_mem_req.valid && i_mem_ready)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Error %s: request to %h was not expected", cur_name, o_mem_req.addr);
        errors++;
      end
      else
      begin
        check_value("request", exp_q.pop_front(), o_mem_req);
        check_value("current_loop", loop_q.pop_front(), o_status.current_loop);
        void'(set_q.pop_front());
        // The set counter already points at the next request of the grid
        check_value("current_set", (set_q.size() != 0) ? set_q[0] : 0,
                    o_status.current_set);
      end
      if (!mem.exists(o_mem_req.addr))
        mem[o_mem_req.addr] = fill_word(o_mem_req.addr);
      if (o_mem_req.write)
        mem[o_mem_req.addr] = merge_bytes(mem[o_mem_req.addr], o_mem_req.data,
                                          o_mem_req.byte_mask);
      else
      begin
        if (last_was_write && cur.corrupt_en && mem.exists(cur.corrupt_addr))
          mem[cur.corrupt_addr][7:0] = ~mem[cur.corrupt_addr][7:0];
        rsp_q.push_back(mem[o_mem_req.addr]);
        due_q.push_back(cyc + ($random(seed) & 3));
      end
      last_was_write = o_mem_req.write;
      acc_count++;
      if (cur.disable_after != 0 && acc_count == cur.disable_after)
        dis_pending = 1'b1;
    end
  end

  // Responses and ready change on the falling edge
  always @(negedge rtl_clk)
  begin
    i_mem_ready = ($random(seed) & 3) != 0;
    i_mem_rsp   = '0;
    if (rsp_q.size() != 0 && due_q[0] <= cyc)
    begin
      i_mem_rsp.valid = 1'b1;
      i_mem_rsp.data  = rsp_q.pop_front();
      void'(due_q.pop_front());
    end
  end

  task automatic run_row(input int idx);
    logic [31:0]   a;
    logic [31:0]   expw;
    mwae_err_rec_t exp_rec;
    int            last;
    cur            = table_rows[idx];
    cur_name       = row_names[idx];
    acc_count      = 0;
    last_was_write = 1'b0;
    dis_pending    = 1'b0;
    mem.delete();
    build_expected(cur);
    @(negedge rtl_clk);
    cfg = cur.cfg;
    repeat (2) @(negedge rtl_clk);
    check_value("busy after start", !cur.exp_illegal, o_status.busy);
    check_value("config_error", cur.exp_illegal, o_status.config_error);
    while (!o_status.done)
    begin
      if (dis_pending && !cfg.force_disable)
      begin
        cfg.force_disable = 1'b1;
        acc_at_disable    = acc_count;
      end
      @(negedge rtl_clk);
    end
    check_value("busy at done", 0, o_status.busy);
    if (cur.exp_illegal)
      check_value("request count", 0, acc_count);
    else if (cur.disable_after != 0)
    begin
      if (acc_count > acc_at_disable + 1 || exp_q.size() == 0)
      begin
        $display("Error %s: requests continued after force disable", cur_name);
        errors++;
      end
    end
    else
    begin
      check_value("remaining requests", 0, exp_q.size());
      last = cur.cfg.num_loops - 1;
      for (int s = 0; s <= cur.cfg.num_sets; s++)
        for (int i = 0; i <= cur.cfg.num_incrs; i++)
        begin
          a    = grid_addr(cur, s, i);
          expw = merge_bytes(fill_word(a), loop_pattern(cur, last), cur.cfg.byte_mask);
          if (cur.corrupt_en && a == cur.corrupt_addr)
            expw[7:0] = ~expw[7:0];
          check_value("memory word", expw, mem.exists(a) ? mem[a] : 32'hx);
        end
    end
    check_value("error_found", cur.corrupt_en, o_status.error_found);
    if (cur.corrupt_en)
    begin
      // The first corruption is caught in loop 0 and kept
      exp_rec = '{addr: cur.corrupt_addr, expected: loop_pattern(cur, 0),
                  observed: loop_pattern(cur, 0) ^ 32'h0000_00ff, loop: 8'd0,
                  rsp_err: 1'b0};
      check_value("error record", exp_rec, o_err_rec);
      i_clear_error = 1'b1;
      @(negedge rtl_clk);
      i_clear_error = 1'b0;
      check_value("error_found after clear", 0, o_status.error_found);
      check_value("record after clear", 0, o_err_rec);
    end
    cfg.algorithm     = 3'd0;
    cfg.force_disable = 1'b0;
    @(negedge rtl_clk);
    check_value("done when idle", 0, o_status.done);
    check_value("busy when idle", 0, o_status.busy);
  endtask

  initial
  begin
    rtl_clk       = 1'b0;
    reset_n       = 1'b0;
    cfg           = '0;
    i_clear_error = 1'b0;
    i_mem_ready   = 1'b0;
    i_mem_rsp     = '0;
    cyc           = 0;
    errors        = 0;
    cur           = '0;
    cur_name      = "reset";
    set_row(0, "grid", 32'h1000, 26'd1, 26'd4, 32'ha5c3_0f1e, 4'hf, 0, 2, 1, 2, 0, 0, 0);
    set_row(1, "single", 32'h2000_0040, 0, 0, 32'h1234_5678, 4'hf, 0, 0, 0, 1, 0, 0, 0);
    set_row(2, "pincr_mask", 32'h4000, 26'd2, 0, 32'h10ff_20fe, 4'b0101, 1, 3, 0, 3,
            0, 0, 0);
    set_row(3, "corrupt", 32'h8000, 26'd1, 26'd2, 32'hdead_beef, 4'hf, 0, 1, 1, 2,
            32'h8040, 0, 0);
    set_row(4, "misaligned", 32'h9004, 26'd1, 0, 32'h1, 4'hf, 0, 0, 0, 1, 0, 1, 0);
    set_row(5, "zero_loops", 32'ha000, 26'd1, 0, 32'h2, 4'hf, 0, 0, 0, 0, 0, 1, 0);
    set_row(6, "disable", 32'hc000, 26'd1, 26'd8, 32'h0bad_f00d, 4'hf, 0, 7, 3, 4,
            0, 0, 10);
    limit = 0;
    for (int r = 0; r < NUM_ROWS; r++)
      limit += request_count(table_rows[r]);
    limit = 2 * limit * 8 + 200 * NUM_ROWS;
    repeat (10) @(negedge rtl_clk);
    reset_n = 1'b1;
    @(negedge rtl_clk);
    check_value("idle after reset", 0, {o_mem_req.valid, o_status.busy, o_status.done,
                                        o_status.config_error, o_status.error_found});
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    $display("Rows run: %0d, errors: %0d", NUM_ROWS, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- verif/mwae_properties.sv
/*
  Concurrent checks on the request channel and the status word.
  Bound into every instance of mwae_top.
*/
`timescale 1ns/1ps

module mwae_properties
  import mwae_pkg::*;
(
  input logic          rtl_clk,
  input logic          reset_n,
  input logic          i_mem_ready,
  input mwae_mem_req_t o_mem_req,
  input mwae_status_t  o_status
);

  // A stalled request keeps every field until it is accepted
  assert property (@(posedge rtl_clk) disable iff (!reset_n)
    (o_mem_req.valid && !i_mem_ready) |=> (o_mem_req.valid && $stable(o_mem_req)))
    else $error("request changed while stalled");

  assert property (@(posedge rtl_clk) disable iff (!reset_n)
    !(o_status.busy && o_status.done))
    else $error("busy and done high together");

  assert property (@(posedge rtl_clk) disable iff (!reset_n)
    o_mem_req.valid |-> o_status.busy)
    else $error("request issued while not busy");

endmodule

bind mwae_top mwae_properties i_mwae_properties (
  .rtl_clk     (rtl_clk),
  .reset_n     (reset_n),
  .i_mem_ready (i_mem_ready),
  .o_mem_req   (o_mem_req),
  .o_status    (o_status)
);

//--- rtl/mwae_top.sv
/*
  Memory write-and-verify engine, algorithm 1a with self-checking.
  i_cfg is a level from software and is latched at test start.
  force_disable and the algorithm field are also watched live.
*/
`timescale 1ns/1ps
`include "mwae_defs.svh"

module mwae_top
  import mwae_pkg::*;
(
  input  logic          rtl_clk,
  input  logic          reset_n,
  input  mwae_cfg_t     i_cfg,
  input  logic          i_clear_error,
  input  logic          i_mem_ready,
  input  mwae_mem_rsp_t i_mem_rsp,
  output mwae_mem_req_t o_mem_req,
  output mwae_status_t  o_status,
  output mwae_err_rec_t o_err_rec
);

  logic                   lock;
  logic                   run;
  logic                   busy;
  logic                   done;
  logic                   config_error;
  logic                   illegal;
  logic                   seq_done;
  logic                   rd_push;
  logic                   rd_space;
  logic                   rd_idle;
  logic                   mismatch;
  logic                   error_found;
  logic [`MWAE_CNT_W-1:0] cur_loop;
  logic [`MWAE_CNT_W-1:0] cur_set;
  mwae_locked_t           locked;
  mwae_rd_exp_t           rd_expect;
  mwae_err_rec_t          chk_rec;

  mwae_control_fsm i_mwae_control_fsm (
    .rtl_clk         (rtl_clk),
    .reset_n         (reset_n),
    .i_algorithm     (i_cfg.algorithm),
    .i_force_disable (i_cfg.force_disable),
    .i_illegal       (illegal),
    .i_seq_done      (seq_done),
    .o_lock          (lock),
    .o_run           (run),
    .o_busy          (busy),
    .o_done          (done),
    .o_config_error  (config_error)
  );

  mwae_config_regs i_mwae_config_regs (
    .rtl_clk   (rtl_clk),
    .reset_n   (reset_n),
    .i_cfg     (i_cfg),
    .i_lock    (lock),
    .o_locked  (locked),
    .o_illegal (illegal)
  );

  alg1a_sequencer i_alg1a_sequencer (
    .rtl_clk         (rtl_clk),
    .reset_n         (reset_n),
    .i_run           (run),
    .i_force_disable (i_cfg.force_disable),
    .i_locked        (locked),
    .i_mem_ready     (i_mem_ready),
    .i_rd_space      (rd_space),
    .i_rd_idle       (rd_idle),
    .o_mem_req       (o_mem_req),
    .o_rd_push       (rd_push),
    .o_rd_expect     (rd_expect),
    .o_done          (seq_done),
    .o_loop          (cur_loop),
    .o_set           (cur_set)
  );

  alg1a_checker i_alg1a_checker (
    .rtl_clk     (rtl_clk),
    .reset_n     (reset_n),
    .i_rd_push   (rd_push),
    .i_rd_expect (rd_expect),
    .i_mem_rsp   (i_mem_rsp),
    .o_rd_space  (rd_space),
    .o_rd_idle   (rd_idle),
    .o_mismatch  (mismatch),
    .o_err_rec   (chk_rec)
  );

  mwae_error_log i_mwae_error_log (
    .rtl_clk       (rtl_clk),
    .reset_n       (reset_n),
    .i_clear_error (i_clear_error),
    .i_mismatch    (mismatch),
    .i_err_rec     (chk_rec),
    .o_error_found (error_found),
    .o_err_rec     (o_err_rec)
  );

  assign o_status = '{busy: busy, done: done, config_error: config_error,
                      error_found: error_found, current_loop: cur_loop,
                      current_set: cur_set};

endmodule

//--- rtl/mwae_error_log.sv
/*
  First-error log.
  Later mismatches are ignored until software clears the log.
  A clear in the same cycle as a mismatch wins.
*/
`timescale 1ns/1ps

module mwae_error_log
  import mwae_pkg::*;
(
  input  logic          rtl_clk,
  input  logic          reset_n,
  input  logic          i_clear_error,
  input  logic          i_mismatch,
  input  mwae_err_rec_t i_err_rec,
  output logic          o_error_found,
  output mwae_err_rec_t o_err_rec
);

  always_ff @(posedge rtl_clk)
  begin
    if (!reset_n)
    begin
      o_error_found <= 1'b0;
      o_err_rec     <= '0;
    end
    else if (i_clear_error)
    begin
      o_error_found <= 1'b0;
      o_err_rec     <= '0;
    end
    else if (i_mismatch && !o_error_found)
    begin
      // Sticky until cleared
      o_error_found <= 1'b1;
      o_err_rec     <= i_err_rec;
    end
  end

endmodule

//--- alg1a/alg1a_checker.sv
/*
  Self-check for algorithm 1a reads.
  Responses must come back in request order, one per read.
  Only bytes enabled by the mask are compared.
*/
`timescale 1ns/1ps
`include "mwae_defs.svh"

module alg1a_checker
  import mwae_pkg::*;
(
  input  logic          rtl_clk,
  input  logic          reset_n,
  input  logic          i_rd_push,
  input  mwae_rd_exp_t  i_rd_expect,
  input  mwae_mem_rsp_t i_mem_rsp,
  output logic          o_rd_space,
  output logic          o_rd_idle,
  output logic          o_mismatch,
  output mwae_err_rec_t o_err_rec
);

  localparam int PTR_W = $clog2(`MWAE_RD_DEPTH);

  mwae_rd_exp_t            queue [`MWAE_RD_DEPTH];
  mwae_rd_exp_t            head;
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [PTR_W:0]          count;
  logic [`MWAE_DATA_W-1:0] bit_mask;
  logic                    pop;

  assign head = queue[rd_ptr];
  assign pop  = i_mem_rsp.valid;

  always_comb
  begin
    for (int b = 0; b < `MWAE_MASK_W; b++)
      bit_mask[8*b +: 8] = {8{head.mask[b]}};
  end

  always_ff @(posedge rtl_clk)
  begin
    if (i_rd_push)
      queue[wr_ptr] <= i_rd_expect;
  end

  // Pointers wrap naturally because the depth is a power of two
  always_ff @(posedge rtl_clk)
  begin
    if (!reset_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (i_rd_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + {{PTR_W{1'b0}}, i_rd_push} - {{PTR_W{1'b0}}, pop};
    end
  end

  assign o_rd_space = count < (PTR_W+1)'(`MWAE_RD_DEPTH);
  assign o_rd_idle  = count == '0;

  assign o_mismatch = pop && ((((i_mem_rsp.data ^ head.pattern) & bit_mask) != '0) ||
                              i_mem_rsp.err);
  assign o_err_rec  = '{addr: head.addr, expected: head.pattern, observed: i_mem_rsp.data,
                        loop: head.loop, rsp_err: i_mem_rsp.err};

endmodule

//--- alg1a/alg1a_sequencer.sv
/*
  Request generator for algorithm 1a.
  Each loop writes the whole set/increment grid, then reads it back.
  The request is registered and held stable until it is accepted.
  A read is loaded only when the register is free of another read.
*/
`timescale 1ns/1ps
`include "mwae_defs.svh"

module alg1a_sequencer
  import mwae_pkg::*;
(
  input  logic                   rtl_clk,
  input  logic                   reset_n,
  input  logic                   i_run,
  input  logic                   i_force_disable,
  input  mwae_locked_t           i_locked,
  input  logic                   i_mem_ready,
  input  logic                   i_rd_space,
  input  logic                   i_rd_idle,
  output mwae_mem_req_t          o_mem_req,
  output logic                   o_rd_push,
  output mwae_rd_exp_t           o_rd_expect,
  output logic                   o_done,
  output logic [`MWAE_CNT_W-1:0] o_loop,
  output logic [`MWAE_CNT_W-1:0] o_set
);

  typedef enum logic [1:0] {
    SQ_WRITE,
    SQ_READ,
    SQ_WAIT,
    SQ_FINISH
  } seq_phase_e;

  seq_phase_e              phase;
  logic [`MWAE_CNT_W-1:0]  loop_cnt;
  logic [`MWAE_CNT_W-1:0]  set_cnt;
  logic [`MWAE_CNT_W-1:0]  incr_cnt;
  logic [`MWAE_ADDR_W-1:0] set_base;
  logic [`MWAE_ADDR_W-1:0] addr_acc;
  logic [`MWAE_DATA_W-1:0] pattern;
  logic                    slot_free;
  logic                    load;
  logic                    incr_wrap;
  logic                    set_wrap;
  logic                    drained;

  assign pattern = i_locked.cfg.pattern +
                   (i_locked.cfg.pattern_incr ? `MWAE_DATA_W'(loop_cnt) : '0);

  // A write being accepted frees the slot, a read being accepted does not,
  // so the checker count is current before the next read is loaded
  assign slot_free = !o_mem_req.valid || (o_mem_req.write && i_mem_ready);
  assign load      = i_run && !i_force_disable && slot_free &&
                     ((phase == SQ_WRITE) || ((phase == SQ_READ) && i_rd_space));
  assign incr_wrap = incr_cnt == i_locked.last_incr;
  assign set_wrap  = set_cnt == i_locked.last_set;
  assign drained   = !o_mem_req.valid && i_rd_idle;

  always_ff @(posedge rtl_clk)
  begin
    if (!reset_n)
    begin
      phase           <= SQ_WRITE;
      loop_cnt        <= '0;
      set_cnt         <= '0;
      incr_cnt        <= '0;
      o_mem_req.valid <= 1'b0;
    end
    else if (!i_run)
    begin
      phase           <= SQ_WRITE;
      loop_cnt        <= '0;
      set_cnt         <= '0;
      incr_cnt        <= '0;
      o_mem_req.valid <= 1'b0;
      set_base        <= i_locked.cfg.start_addr;
      addr_acc        <= i_locked.cfg.start_addr;
    end
    else
    begin
      if (o_mem_req.valid && i_mem_ready)
        o_mem_req.valid <= 1'b0;

      if (load)
      begin
        o_mem_req.valid     <= 1'b1;
        o_mem_req.write     <= phase == SQ_WRITE;
        o_mem_req.addr      <= addr_acc;
        o_mem_req.data      <= pattern;
        o_mem_req.byte_mask <= i_locked.cfg.byte_mask;
        // Accumulators replace set * set_stride + incr * incr_stride
        if (!incr_wrap)
        begin
          incr_cnt <= incr_cnt + 1'b1;
          addr_acc <= addr_acc + i_locked.incr_stride;
        end
        else if (!set_wrap)
        begin
          incr_cnt <= '0;
          set_cnt  <= set_cnt + 1'b1;
          set_base <= set_base + i_locked.set_stride;
          addr_acc <= set_base + i_locked.set_stride;
        end
        else
        begin
          incr_cnt <= '0;
          set_cnt  <= '0;
          set_base <= i_locked.cfg.start_addr;
          addr_acc <= i_locked.cfg.start_addr;
          phase    <= (phase == SQ_WRITE) ? SQ_READ : SQ_WAIT;
        end
      end
      else if (i_force_disable && (phase != SQ_FINISH) && drained)
      begin
        phase <= SQ_FINISH;
      end
      else if ((phase == SQ_WAIT) && drained)
      begin
        if (loop_cnt == i_locked.last_loop)
        begin
          phase <= SQ_FINISH;
        end
        else
        begin
          loop_cnt <= loop_cnt + 1'b1;
          phase    <= SQ_WRITE;
        end
      end
    end
  end

  // Loops only advance once drained, so loop_cnt matches an accepted read
  assign o_rd_push   = o_mem_req.valid && !o_mem_req.write && i_mem_ready;
  assign o_rd_expect = '{addr: o_mem_req.addr, pattern: o_mem_req.data,
                         mask: o_mem_req.byte_mask, loop: loop_cnt};
  assign o_done      = phase == SQ_FINISH;
  assign o_loop      = loop_cnt;
  assign o_set       = set_cnt;

endmodule

//--- rtl/mwae_control_fsm.sv
/*
  Test-level state machine.
  A test starts when the algorithm field becomes nonzero in idle.
  Done holds until software returns the algorithm field to zero.
*/
`timescale 1ns/1ps

module mwae_control_fsm
  import mwae_pkg::*;
(
  input  logic       rtl_clk,
  input  logic       reset_n,
  input  logic [2:0] i_algorithm,
  input  logic       i_force_disable,
  input  logic       i_illegal,
  input  logic       i_seq_done,
  output logic       o_lock,
  output logic       o_run,
  output logic       o_busy,
  output logic       o_done,
  output logic       o_config_error
);

  mwae_state_e state;
  mwae_state_e state_nxt;

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (i_algorithm != 3'd0)
          state_nxt = ST_CHECK;
      // The configuration was latched on the way out of idle
      ST_CHECK:
        state_nxt = i_illegal ? ST_FAIL : ST_RUN;
      ST_RUN:
        if (i_seq_done)
          state_nxt = ST_DONE;
        else if (i_force_disable)
          state_nxt = ST_DRAIN;
      ST_DRAIN:
        if (i_seq_done)
          state_nxt = ST_DONE;
      ST_FAIL, ST_DONE:
        if (i_algorithm == 3'd0)
          state_nxt = ST_IDLE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge rtl_clk)
  begin
    if (!reset_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  assign o_lock         = (state == ST_IDLE) && (i_algorithm != 3'd0);
  // The sequencer keeps running while it drains after a forced disable
  assign o_run          = (state == ST_RUN) || (state == ST_DRAIN);
  assign o_busy         = o_run;
  assign o_done         = (state == ST_DONE) || (state == ST_FAIL);
  assign o_config_error = state == ST_FAIL;

endmodule

//--- rtl/mwae_config_regs.sv
/*
  Configuration latch for the engine.
  The configuration is sampled once per test, on i_lock.
  o_illegal is valid from the cycle after the lock.
*/
`timescale 1ns/1ps
`include "mwae_defs.svh"

module mwae_config_regs
  import mwae_pkg::*;
(
  input  logic         rtl_clk,
  input  logic         reset_n,
  input  mwae_cfg_t    i_cfg,
  input  logic         i_lock,
  output mwae_locked_t o_locked,
  output logic         o_illegal
);

  logic bad_algorithm;
  logic bad_alignment;
  logic bad_loops;

  always_ff @(posedge rtl_clk)
  begin
    if (!reset_n)
    begin
      o_locked <= '0;
    end
    else if (i_lock)
    begin
      o_locked.cfg         <= i_cfg;
      // Register values count lines, the engine works in bytes
      o_locked.incr_stride <= `MWAE_ADDR_W'(i_cfg.addr_incr) << `MWAE_LINE_SHIFT;
      o_locked.set_stride  <= `MWAE_ADDR_W'(i_cfg.set_offset) << `MWAE_LINE_SHIFT;
      o_locked.last_incr   <= i_cfg.num_incrs;
      o_locked.last_set    <= i_cfg.num_sets;
      o_locked.last_loop   <= i_cfg.num_loops - 1'b1;
    end
  end

  assign bad_algorithm = o_locked.cfg.algorithm != 3'(`MWAE_ALG_1A);
  assign bad_alignment = o_locked.cfg.start_addr[`MWAE_LINE_SHIFT-1:0] != '0;

  // There is no infinite looping, so a loop count of zero is rejected
  assign bad_loops     = o_locked.cfg.num_loops == '0;

  assign o_illegal = bad_algorithm || bad_alignment || bad_loops;

endmodule

//--- common/mwae_pkg.sv
/*
  Types shared by the write-and-verify engine.
  Stride fields are in lines and are shifted up by MWAE_LINE_SHIFT when locked.
*/
`include "mwae_defs.svh"

package mwae_pkg;

  typedef struct packed {
    logic [2:0]                                   algorithm;
    logic [`MWAE_ADDR_W-1:0]                      start_addr;
    logic [`MWAE_ADDR_W-`MWAE_LINE_SHIFT-1:0]     addr_incr;
    logic [`MWAE_ADDR_W-`MWAE_LINE_SHIFT-1:0]     set_offset;
    logic [`MWAE_DATA_W-1:0]                      pattern;
    logic [`MWAE_MASK_W-1:0]                      byte_mask;
    logic                                         pattern_incr;
    logic [`MWAE_CNT_W-1:0]                       num_incrs;
    logic [`MWAE_CNT_W-1:0]                       num_sets;
    logic [`MWAE_CNT_W-1:0]                       num_loops;
    logic                                         force_disable;
  } mwae_cfg_t;

  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [`MWAE_ADDR_W-1:0] addr;
    logic [`MWAE_DATA_W-1:0] data;
    logic [`MWAE_MASK_W-1:0] byte_mask;
  } mwae_mem_req_t;

  typedef struct packed {
    logic                    valid;
    logic [`MWAE_DATA_W-1:0] data;
    logic                    err;
  } mwae_mem_rsp_t;

  typedef struct packed {
    logic                   busy;
    logic                   done;
    logic                   config_error;
    logic                   error_found;
    logic [`MWAE_CNT_W-1:0] current_loop;
    logic [`MWAE_CNT_W-1:0] current_set;
  } mwae_status_t;

  typedef struct packed {
    logic [`MWAE_ADDR_W-1:0] addr;
    logic [`MWAE_DATA_W-1:0] expected;
    logic [`MWAE_DATA_W-1:0] observed;
    logic [`MWAE_CNT_W-1:0]  loop;
    logic                    rsp_err;
  } mwae_err_rec_t;

  // One outstanding read as the checker expects it back
  typedef struct packed {
    logic [`MWAE_ADDR_W-1:0] addr;
    logic [`MWAE_DATA_W-1:0] pattern;
    logic [`MWAE_MASK_W-1:0] mask;
    logic [`MWAE_CNT_W-1:0]  loop;
  } mwae_rd_exp_t;

  typedef struct packed {
    mwae_cfg_t               cfg;
    logic [`MWAE_ADDR_W-1:0] incr_stride;
    logic [`MWAE_ADDR_W-1:0] set_stride;
    logic [`MWAE_CNT_W-1:0]  last_incr;
    logic [`MWAE_CNT_W-1:0]  last_set;
    logic [`MWAE_CNT_W-1:0]  last_loop;
  } mwae_locked_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHECK,
    ST_RUN,
    ST_DRAIN,
    ST_FAIL,
    ST_DONE
  } mwae_state_e;

endpackage

//--- common/mwae_defs.svh
/*
  Global sizes for the memory write-and-verify engine.
  The data path is one 32-bit word with a 4-bit byte mask.
  Strides are given in lines of 1 << MWAE_LINE_SHIFT bytes.
  MWAE_RD_DEPTH must be a power of two.
*/
`ifndef MWAE_DEFS_SVH
`define MWAE_DEFS_SVH

`define MWAE_ADDR_W     32
`define MWAE_DATA_W     32
`define MWAE_MASK_W     4
`define MWAE_CNT_W      8
`define MWAE_LINE_SHIFT 6
`define MWAE_RD_DEPTH   4

// Only algorithm 1a is implemented
`define MWAE_ALG_1A     1

`endif
